/* source/lsu_cfg_pkg.sv */
// DCCM configuration constants
`default_nettype none

package lsu_cfg_pkg;

  // **************************************************************************
  // Memory map
  // **************************************************************************

  localparam logic [31:0] DCCM_BASE = 32'hf004_0000;  // First byte of the DCCM window
  localparam int unsigned DCCM_SIZE = 1024;           // Window size in bytes
  localparam int          DCCM_BITS = 10;             // Byte offset inside the window

  // Word index into the array, also the DCCM port address width
  localparam int DCCM_WORD_BITS = 8;

  // **************************************************************************
  // Data widths
  // **************************************************************************

  localparam int DATA_WIDTH  = 32;  // One data word
  localparam int ECC_WIDTH   = 7;   // Six Hamming bits plus overall parity

  // Stored word, check code sits above the data
  localparam int FDATA_WIDTH = DATA_WIDTH + ECC_WIDTH;

endpackage

`default_nettype wire

/* source/lsu_types_pkg.sv */
// Load/store unit types
`default_nettype none

package lsu_types_pkg;
  import lsu_cfg_pkg::*;

  // **************************************************************************
  // Plain vectors
  // **************************************************************************

  typedef logic [DATA_WIDTH-1:0]     lsu_data_t;    // Register-file data word
  typedef logic [31:0]               lsu_addr_t;    // Byte address
  typedef logic [DCCM_WORD_BITS-1:0] dccm_addr_t;   // Word index into the DCCM
  typedef logic [FDATA_WIDTH-1:0]    dccm_fdata_t;  // Data plus check code
  typedef logic [ECC_WIDTH-1:0]      ecc_t;         // SECDED check code
  typedef logic [11:0]               lsu_offset_t;  // Immediate from the instruction
  typedef logic [3:0]                byte_en_t;     // One bit per byte lane

  // **************************************************************************
  // Enumerations
  // **************************************************************************

  // Access size, encoded as the funct3 low bits of a load or store
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  // Exception kind reported in dc3
  // Misaligned wins over access fault, access fault over double ECC
  typedef enum logic [1:0] {
    ERR_NONE         = 2'b00,
    ERR_MISALIGNED   = 2'b01,
    ERR_ACCESS_FAULT = 2'b10,
    ERR_ECC_DOUBLE   = 2'b11
  } lsu_err_e;

endpackage

`default_nettype wire

/* source/lsu_pipe_if.sv */
// Control to DCCM pipeline link
`timescale 1ns/100ps
`default_nettype none

interface lsu_pipe_if;
  import lsu_types_pkg::*;

  // dc1 stage
  logic       dc1_access;      // Valid, aligned, inside the DCCM
  dccm_addr_t dc1_word;        // Word to read

  // dc2 stage
  logic       dc2_access;
  logic       dc2_store;
  lsu_size_e  dc2_size;
  logic       dc2_unsigned;    // Zero-extend a load
  logic [1:0] dc2_byte_off;    // Byte lane within the word
  dccm_addr_t dc2_word;
  lsu_data_t  dc2_store_data;  // Unaligned store operand
  logic       dc2_ecc_double;  // Uncorrectable word seen in dc2

  modport ctl (
    output dc1_access, dc1_word,
    output dc2_access, dc2_store, dc2_size, dc2_unsigned, dc2_byte_off, dc2_word,
    output dc2_store_data,
    input  dc2_ecc_double
  );

  modport dccm (
    input  dc1_access, dc1_word,
    input  dc2_access, dc2_store, dc2_size, dc2_unsigned, dc2_byte_off, dc2_word,
    input  dc2_store_data,
    output dc2_ecc_double
  );

endinterface

`default_nettype wire

/* source/lsu_ecc.sv */
// SECDED encoder and corrector
`timescale 1ns/100ps
`default_nettype none

module lsu_ecc (
  input  lsu_types_pkg::lsu_data_t din,
  input  lsu_types_pkg::ecc_t      ecc_in,      // Stored check code
  output lsu_types_pkg::ecc_t      ecc_out,     // Check code of din
  output lsu_types_pkg::lsu_data_t dout,        // Corrected data
  output logic                     single_err,  // One bit flipped, corrected
  output logic                     double_err   // Two bits flipped, not correctable
);
  import lsu_types_pkg::*;
  import lsu_cfg_pkg::*;

  logic [ECC_WIDTH-2:0] syndrome;    // Position of the failing bit
  logic                 parity_odd;  // Overall parity of the received word

  // Hamming position of data bit idx
  // Positions 1..38, powers of two hold the check bits
  function automatic logic [ECC_WIDTH-2:0] data_pos(input int idx);
    int cnt;
    data_pos = '0;
    cnt      = 0;
    for (int p = 3; p < FDATA_WIDTH; p++) begin
      if ((p & (p - 1)) != 0) begin  // Skip 4, 8, 16, 32
        if (cnt == idx) begin
          data_pos = (ECC_WIDTH - 1)'(p);
        end
        cnt++;
      end
    end
  endfunction

  // Data bits covered by check bit k
  function automatic lsu_data_t cover_mask(input int k);
    logic [ECC_WIDTH-2:0] pos;
    cover_mask = '0;
    for (int j = 0; j < DATA_WIDTH; j++) begin
      pos           = data_pos(j);
      cover_mask[j] = pos[k];
    end
  endfunction

  // **************************************************************************
  // Encode
  // **************************************************************************

  always_comb begin
    for (int k = 0; k < ECC_WIDTH - 1; k++) begin
      ecc_out[k] = ^(din & cover_mask(k));
    end
    ecc_out[ECC_WIDTH-1] = (^din) ^ (^ecc_out[ECC_WIDTH-2:0]);  // Overall parity on top
  end

  // **************************************************************************
  // Check and correct
  // **************************************************************************

  assign syndrome   = ecc_out[ECC_WIDTH-2:0] ^ ecc_in[ECC_WIDTH-2:0];
  assign parity_odd = (^din) ^ (^ecc_in);  // Zero for a clean codeword

  // Odd parity means one flip, possibly in a check bit or the parity bit itself
  assign single_err = parity_odd;
  assign double_err = ~parity_odd & (syndrome != '0);

  always_comb begin
    for (int j = 0; j < DATA_WIDTH; j++) begin
      dout[j] = din[j] ^ (single_err && (syndrome == data_pos(j)));
    end
  end

endmodule

`default_nettype wire

/* source/lsu_lsc_ctl.sv */
// Load/store control pipeline
`timescale 1ns/100ps
`default_nettype none

module lsu_lsc_ctl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid,       // New access this cycle
  input  logic                       req_store,
  input  lsu_types_pkg::lsu_size_e   req_size,
  input  logic                       req_unsigned,
  input  lsu_types_pkg::lsu_addr_t   req_rs1,         // Base register
  input  lsu_types_pkg::lsu_offset_t req_offset,      // Signed immediate
  input  lsu_types_pkg::lsu_data_t   req_store_data,
  lsu_pipe_if.ctl                    pipe,
  output logic                       lsu_error_valid,
  output lsu_types_pkg::lsu_err_e    lsu_error_kind,
  output logic                       lsu_error_store,
  output lsu_types_pkg::lsu_addr_t   lsu_error_addr,
  output logic                       lsu_idle
);
  import lsu_types_pkg::*;
  import lsu_cfg_pkg::*;

  // Request as captured into dc1
  logic        dc1_valid;
  logic        dc1_store;
  logic        dc1_unsigned;
  lsu_size_e   dc1_size;
  lsu_addr_t   dc1_rs1;
  lsu_offset_t dc1_offset;
  lsu_data_t   dc1_store_data;

  lsu_addr_t   dc1_addr;        // Effective address
  logic        dc1_in_dccm;
  logic        dc1_misaligned;
  lsu_err_e    dc1_exc;

  logic        dc2_valid;       // Any access, faulting or not
  lsu_addr_t   dc2_addr;
  lsu_err_e    dc2_exc;         // Exception found in dc1
  lsu_err_e    dc2_err;         // Final kind after ECC fold
  logic        dc3_valid;

  // **************************************************************************
  // dc1: request capture and address checks
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dc1_valid <= 1'b0;
    end else begin
      dc1_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin  // Operands only move with a strobe
      dc1_store      <= req_store;
      dc1_unsigned   <= req_unsigned;
      dc1_size       <= req_size;
      dc1_rs1        <= req_rs1;
      dc1_offset     <= req_offset;
      dc1_store_data <= req_store_data;
    end
  end

  assign dc1_addr = dc1_rs1 + {{20{dc1_offset[11]}}, dc1_offset};  // rs1 + sext(imm)

  // Half on odd byte, word off a 4-byte boundary
  assign dc1_misaligned = ((dc1_size == SIZE_HALF) & dc1_addr[0]) |
                          ((dc1_size == SIZE_WORD) & (|dc1_addr[1:0]));

  assign dc1_in_dccm = (dc1_addr - DCCM_BASE) < DCCM_SIZE;  // Wraps below the base

  always_comb begin
    if (dc1_misaligned) begin
      dc1_exc = ERR_MISALIGNED;
    end else if (!dc1_in_dccm) begin
      dc1_exc = ERR_ACCESS_FAULT;  // No bus behind the DCCM
    end else begin
      dc1_exc = ERR_NONE;
    end
  end

  // Only clean accesses touch the array
  assign pipe.dc1_access = dc1_valid & (dc1_exc == ERR_NONE);
  assign pipe.dc1_word   = dc1_addr[DCCM_BITS-1:2];

  // **************************************************************************
  // dc2: access fields for DCCM control
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dc2_valid       <= 1'b0;
      pipe.dc2_access <= 1'b0;
    end else begin
      dc2_valid       <= dc1_valid;
      pipe.dc2_access <= pipe.dc1_access;
    end
  end

  always_ff @(posedge clk) begin
    pipe.dc2_store      <= dc1_store;
    pipe.dc2_size       <= dc1_size;
    pipe.dc2_unsigned   <= dc1_unsigned;
    pipe.dc2_store_data <= dc1_store_data;
    dc2_addr            <= dc1_addr;
    dc2_exc             <= dc1_exc;
  end

  assign pipe.dc2_byte_off = dc2_addr[1:0];
  assign pipe.dc2_word     = dc2_addr[DCCM_BITS-1:2];

  // Address exceptions keep priority over the ECC result
  assign dc2_err = (dc2_exc != ERR_NONE) ? dc2_exc :
                   pipe.dc2_ecc_double   ? ERR_ECC_DOUBLE : ERR_NONE;

  // **************************************************************************
  // dc3: registered exception report
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dc3_valid       <= 1'b0;
      lsu_error_valid <= 1'b0;
    end else begin
      dc3_valid       <= dc2_valid;
      lsu_error_valid <= dc2_valid & (dc2_err != ERR_NONE);
    end
  end

  always_ff @(posedge clk) begin
    lsu_error_kind  <= dc2_err;
    lsu_error_store <= pipe.dc2_store;
    lsu_error_addr  <= dc2_addr;  // Effective address, as for mtval
  end

  assign lsu_idle = ~(dc1_valid | dc2_valid | dc3_valid);  // Nothing in flight

endmodule

`default_nettype wire

/* source/lsu_dccm_ctl.sv */
// DCCM access control
`timescale 1ns/100ps
`default_nettype none

module lsu_dccm_ctl (
  input  logic                       clk,
  input  logic                       rst_n,
  input  lsu_types_pkg::dccm_fdata_t dccm_rd_data,
  lsu_pipe_if.dccm                   pipe,
  output logic                       dccm_rden,
  output lsu_types_pkg::dccm_addr_t  dccm_rd_addr,
  output logic                       dccm_wren,
  output lsu_types_pkg::dccm_addr_t  dccm_wr_addr,
  output lsu_types_pkg::dccm_fdata_t dccm_wr_data,
  output logic                       lsu_result_valid,
  output lsu_types_pkg::lsu_data_t   lsu_result_data,
  output logic                       lsu_single_ecc_error_incr
);
  import lsu_types_pkg::*;
  import lsu_cfg_pkg::*;

  lsu_data_t  corr_data;     // Array word after correction
  logic       rd_single;
  logic       rd_double;
  logic       fwd_dc3;       // Store in dc3 hits this word
  logic       fwd_last;      // Write of the previous edge hits this word
  logic       fwd_hit;
  lsu_data_t  word_dc2;      // Current value of the addressed word
  logic       dc2_load;
  logic       dc2_double;
  byte_en_t   byte_en;
  lsu_data_t  st_shifted;
  lsu_data_t  merged;
  ecc_t       merged_ecc;
  lsu_data_t  ld_shifted;
  lsu_data_t  ld_data;
  logic       last_wr_vld;
  dccm_addr_t last_wr_addr;
  lsu_data_t  last_wr_data;

  // Read for loads and stores alike, stores merge into the old word
  assign dccm_rden    = pipe.dc1_access;
  assign dccm_rd_addr = pipe.dc1_word;

  // **************************************************************************
  // dc2: correct, forward, merge
  // **************************************************************************

  lsu_ecc i_ecc_chk (
    .din       (dccm_rd_data[DATA_WIDTH-1:0]),
    .ecc_in    (dccm_rd_data[FDATA_WIDTH-1:DATA_WIDTH]),
    .ecc_out   (),
    .dout      (corr_data),
    .single_err(rd_single),
    .double_err(rd_double)
  );

  // Array returns old data while a write is pending or on the same edge
  assign fwd_dc3  = dccm_wren & (dccm_wr_addr == pipe.dc2_word);
  assign fwd_last = last_wr_vld & (last_wr_addr == pipe.dc2_word);
  assign fwd_hit  = fwd_dc3 | fwd_last;

  assign word_dc2 = fwd_dc3  ? dccm_wr_data[DATA_WIDTH-1:0] :
                    fwd_last ? last_wr_data : corr_data;  // Youngest write wins

  assign dc2_load            = pipe.dc2_access & ~pipe.dc2_store;
  assign dc2_double          = pipe.dc2_access & rd_double & ~fwd_hit;  // Stale word ignored
  assign pipe.dc2_ecc_double = dc2_double;

  always_comb begin
    case (pipe.dc2_size)
      SIZE_BYTE: byte_en = byte_en_t'(4'b0001 << pipe.dc2_byte_off);
      SIZE_HALF: byte_en = byte_en_t'(4'b0011 << pipe.dc2_byte_off);
      default:   byte_en = 4'b1111;
    endcase
  end

  assign st_shifted = pipe.dc2_store_data << {pipe.dc2_byte_off, 3'b000};  // Into its lanes

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = byte_en[b] ? st_shifted[8*b +: 8] : word_dc2[8*b +: 8];
    end
  end

  lsu_ecc i_ecc_enc (
    .din       (merged),
    .ecc_in    ('0),
    .ecc_out   (merged_ecc),
    .dout      (),
    .single_err(),
    .double_err()
  );

  // Load alignment and extension
  assign ld_shifted = word_dc2 >> {pipe.dc2_byte_off, 3'b000};

  always_comb begin
    case (pipe.dc2_size)
      SIZE_BYTE: ld_data = {{24{ld_shifted[7] & ~pipe.dc2_unsigned}}, ld_shifted[7:0]};
      SIZE_HALF: ld_data = {{16{ld_shifted[15] & ~pipe.dc2_unsigned}}, ld_shifted[15:0]};
      default:   ld_data = ld_shifted;
    endcase
  end

  // **************************************************************************
  // dc3: write port, result, last-write copy
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dccm_wren                 <= 1'b0;
      lsu_result_valid          <= 1'b0;
      lsu_single_ecc_error_incr <= 1'b0;
      last_wr_vld               <= 1'b0;
    end else begin
      dccm_wren                 <= pipe.dc2_access & pipe.dc2_store & ~dc2_double;
      lsu_result_valid          <= dc2_load & ~dc2_double;  // No result on uncorrectable
      lsu_single_ecc_error_incr <= dc2_load & rd_single & ~fwd_hit;
      last_wr_vld               <= dccm_wren;  // Covers the read on the write edge
    end
  end

  always_ff @(posedge clk) begin
    dccm_wr_addr    <= pipe.dc2_word;
    dccm_wr_data    <= {merged_ecc, merged};
    lsu_result_data <= ld_data;
    last_wr_addr    <= dccm_wr_addr;
    last_wr_data    <= dccm_wr_data[DATA_WIDTH-1:0];
  end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
// Load/store unit top level
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // Request, one-cycle strobe
  input  logic                       req_valid,
  input  logic                       req_store,
  input  logic                       req_unsigned,
  input  lsu_types_pkg::lsu_size_e   req_size,
  input  lsu_types_pkg::lsu_addr_t   req_rs1,
  input  lsu_types_pkg::lsu_offset_t req_offset,
  input  lsu_types_pkg::lsu_data_t   req_store_data,

  // DCCM ports
  input  lsu_types_pkg::dccm_fdata_t dccm_rd_data,    // Returns one cycle after rden
  output logic                       dccm_rden,
  output lsu_types_pkg::dccm_addr_t  dccm_rd_addr,
  output logic                       dccm_wren,
  output lsu_types_pkg::dccm_addr_t  dccm_wr_addr,
  output lsu_types_pkg::dccm_fdata_t dccm_wr_data,

  // Load result
  output logic                       lsu_result_valid,
  output lsu_types_pkg::lsu_data_t   lsu_result_data,

  // Exception
  output logic                       lsu_error_valid,
  output lsu_types_pkg::lsu_err_e    lsu_error_kind,
  output logic                       lsu_error_store,
  output lsu_types_pkg::lsu_addr_t   lsu_error_addr,

  output logic                       lsu_single_ecc_error_incr,  // Corrected-error counter
  output logic                       lsu_idle
);

  lsu_pipe_if i_pipe ();  // dc1/dc2 access info

  // Address, checks and exception pipeline
  lsu_lsc_ctl i_lsc_ctl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_store      (req_store),
    .req_size       (req_size),
    .req_unsigned   (req_unsigned),
    .req_rs1        (req_rs1),
    .req_offset     (req_offset),
    .req_store_data (req_store_data),
    .pipe           (i_pipe.ctl),
    .lsu_error_valid(lsu_error_valid),
    .lsu_error_kind (lsu_error_kind),
    .lsu_error_store(lsu_error_store),
    .lsu_error_addr (lsu_error_addr),
    .lsu_idle       (lsu_idle)
  );

  // Array access, ECC and load data
  lsu_dccm_ctl i_dccm_ctl (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .dccm_rd_data             (dccm_rd_data),
    .pipe                     (i_pipe.dccm),
    .dccm_rden                (dccm_rden),
    .dccm_rd_addr             (dccm_rd_addr),
    .dccm_wren                (dccm_wren),
    .dccm_wr_addr             (dccm_wr_addr),
    .dccm_wr_data             (dccm_wr_data),
    .lsu_result_valid         (lsu_result_valid),
    .lsu_result_data          (lsu_result_data),
    .lsu_single_ecc_error_incr(lsu_single_ecc_error_incr)
  );

endmodule

`default_nettype wire

/* dv/dccm_model.sv */
// Behavioral DCCM array
`timescale 1ns/100ps
`default_nettype none

module dccm_model (
  input  logic                       clk,
  input  logic                       rden,
  input  lsu_types_pkg::dccm_addr_t  rd_addr,
  output lsu_types_pkg::dccm_fdata_t rd_data,   // Valid the cycle after rden
  input  logic                       wren,
  input  lsu_types_pkg::dccm_addr_t  wr_addr,
  input  lsu_types_pkg::dccm_fdata_t wr_data
);
  import lsu_types_pkg::*;
  import lsu_cfg_pkg::*;

  dccm_fdata_t mem [2**DCCM_WORD_BITS];  // Check code above the data

  // All-zero word is a clean codeword
  initial begin
    for (int i = 0; i < 2**DCCM_WORD_BITS; i++) begin
      mem[i] <= '0;
    end
  end

  always @(posedge clk) begin
    if (rden) begin
      rd_data <= mem[rd_addr];  // Old word when written on the same edge
    end
    if (wren) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Error injection, flips every bit set in mask
  task automatic flip_bits(input dccm_addr_t addr, input dccm_fdata_t mask);
    mem[addr] <= mem[addr] ^ mask;
  endtask

endmodule

`default_nettype wire

/* dv/lsu_tb.sv */
// Load/store unit testbench
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
  import lsu_types_pkg::*;
  import lsu_cfg_pkg::*;

  // Cycles per test as requests plus drain gaps
  localparam int LEN_WORD    = 16 * 4 + 8;
  localparam int LEN_SUBW    = 10 * 5 + 8;
  localparam int LEN_MISAL   = 8 * 2 + 8;
  localparam int LEN_FAULT   = 8 + 8;
  localparam int LEN_SINGLE  = 4 * (2 + 8) + 8;
  localparam int LEN_DOUBLE  = 3 * (4 + 16) + 8;
  localparam int CYCLE_LIMIT = 3 + LEN_WORD + LEN_SUBW + LEN_MISAL + LEN_FAULT +
                               LEN_SINGLE + LEN_DOUBLE + 100;

  // One expected dc3 response
  typedef struct packed {
    int        due;        // Cycle count at which it is checked
    logic      res_vld;
    lsu_data_t data;
    logic      err_vld;
    lsu_err_e  kind;
    logic      err_store;
    lsu_addr_t addr;
    logic      sgl;        // Corrected-error pulse
  } exp_t;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_store;
  logic        req_unsigned;
  lsu_size_e   req_size;
  lsu_addr_t   req_rs1;
  lsu_offset_t req_offset;
  lsu_data_t   req_store_data;
  dccm_fdata_t dccm_rd_data;
  logic        dccm_rden;
  dccm_addr_t  dccm_rd_addr;
  logic        dccm_wren;
  dccm_addr_t  dccm_wr_addr;
  dccm_fdata_t dccm_wr_data;
  logic        lsu_result_valid;
  lsu_data_t   lsu_result_data;
  logic        lsu_error_valid;
  lsu_err_e    lsu_error_kind;
  logic        lsu_error_store;
  lsu_addr_t   lsu_error_addr;
  logic        lsu_single_ecc_error_incr;
  logic        lsu_idle;

  int          seed = 32'hd33530f0;
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          chk_mark = 0;   // Counts at the start of the running test
  int          err_mark = 0;
  exp_t        exp_q[$];
  logic [7:0]  shadow [DCCM_SIZE];           // Byte image of the window
  logic        sgl_word [2**DCCM_WORD_BITS];  // One bit flipped in the array
  logic        dbl_word [2**DCCM_WORD_BITS];  // Two bits flipped

  lsu_top i_lsu_top (.*);

  dccm_model i_dccm_model (
    .clk(clk), .rden(dccm_rden), .rd_addr(dccm_rd_addr), .rd_data(dccm_rd_data),
    .wren(dccm_wren), .wr_addr(dccm_wr_addr), .wr_data(dccm_wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Cycle counter and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, responses still outstanding", cyc);
      $display("Simulation failed");
      $finish;
    end
  end

  // ************************************************************************
  // Reference model
  // ************************************************************************

  function automatic int size_bytes(input lsu_size_e size);
    size_bytes = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
  endfunction

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  function automatic lsu_addr_t rand_word_addr();
    rand_word_addr = DCCM_BASE + 4 * rnd(DCCM_SIZE / 4);
  endfunction

  function automatic dccm_addr_t word_of(input lsu_addr_t ea);
    lsu_addr_t rel;
    rel     = ea - DCCM_BASE;
    word_of = rel[DCCM_BITS-1:2];
  endfunction

  // Expected response of one access against the shadow state
  function automatic exp_t predict(input logic store, input logic uns, input lsu_size_e size,
                                   input lsu_addr_t ea);
    exp_t      e;
    int        nb;
    lsu_addr_t rel;
    e           = '0;
    nb          = size_bytes(size);
    rel         = ea - DCCM_BASE;
    e.err_store = store;
    e.addr      = ea;
    if ((ea & lsu_addr_t'(nb - 1)) != 0) begin
      e.kind = ERR_MISALIGNED;
    end else if (ea < DCCM_BASE || ea >= DCCM_BASE + DCCM_SIZE) begin
      e.kind = ERR_ACCESS_FAULT;
    end else if (dbl_word[rel[DCCM_BITS-1:2]]) begin
      e.kind = ERR_ECC_DOUBLE;
    end else if (!store) begin
      for (int i = nb - 1; i >= 0; i--) begin  // Little endian with the top byte first
        e.data = (e.data << 8) | lsu_data_t'(shadow[int'(rel[DCCM_BITS-1:0]) + i]);
      end
      if (!uns && nb < 4 && e.data[8*nb-1]) begin
        e.data = e.data | (32'hffff_ffff << (8 * nb));
      end
      e.res_vld = 1'b1;
      e.sgl     = sgl_word[rel[DCCM_BITS-1:2]];
    end
    e.err_vld = (e.kind != ERR_NONE);
    predict   = e;
  endfunction

  // ************************************************************************
  // Stimulus helpers
  // ************************************************************************

  // One request on the falling edge with ea split randomly into rs1 and offset
  task automatic issue(input logic store, input logic uns, input lsu_size_e size,
                       input lsu_addr_t ea, input lsu_data_t sdata);
    exp_t        e;
    lsu_offset_t off;
    lsu_addr_t   rel;
    off = lsu_offset_t'(rnd(4096));
    @(negedge clk);
    req_valid      = 1'b1;
    req_store      = store;
    req_unsigned   = uns;
    req_size       = size;
    req_offset     = off;
    req_rs1        = ea - {{20{off[11]}}, off};
    req_store_data = sdata;
    e     = predict(store, uns, size, ea);
    e.due = cyc + 3;  // Sample edge, dc2 edge, result edge
    exp_q.push_back(e);
    if (store && !e.err_vld) begin
      rel = ea - DCCM_BASE;
      for (int i = 0; i < size_bytes(size); i++) begin
        shadow[int'(rel[DCCM_BITS-1:0]) + i] = sdata[8*i +: 8];
      end
      sgl_word[rel[DCCM_BITS-1:2]] = 1'b0;  // Word rewritten with a fresh code
    end
  endtask

  task automatic drain();
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);  // Let the last-write copy age out
  endtask

  task automatic end_test(input string name);
    drain();
    $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    chk_mark = checks;
    err_mark = errors;
  endtask

  // ************************************************************************
  // Compare tasks and process
  // ************************************************************************

  task automatic check_data(input string what, input lsu_data_t want, input lsu_data_t got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s expected %h got %h", $time, what, want, got);
    end
  endtask

  task automatic check_addr(input string what, input lsu_addr_t want, input lsu_addr_t got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s expected %h got %h", $time, what, want, got);
    end
  endtask

  task automatic check_err(input string what, input lsu_err_e want, input lsu_err_e got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s expected %s got %s", $time, what, want.name(), got.name());
    end
  endtask

  task automatic check_flag(input string what, input logic want, input logic got);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERR %0t: %s expected %b got %b", $time, what, want, got);
    end
  endtask

  initial begin : compare
    exp_t e;
    logic busy;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      busy = 1'b0;
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
        e    = exp_q.pop_front();
        busy = 1'b1;  // Popped access sits in dc3
      end else begin
        e = '0;  // Outputs stay quiet when nothing is due
      end
      if (exp_q.size() != 0 && exp_q[0].due <= cyc + 2) begin
        busy = 1'b1;  // Sampled access still in dc1 or dc2
      end
      check_flag("result valid", e.res_vld, lsu_result_valid);
      if (e.res_vld) begin
        check_data("load data", e.data, lsu_result_data);
      end
      check_flag("error valid", e.err_vld, lsu_error_valid);
      if (e.err_vld) begin
        check_err("error kind", e.kind, lsu_error_kind);
        check_flag("error store", e.err_store, lsu_error_store);
        check_addr("error address", e.addr, lsu_error_addr);
      end
      check_flag("single ecc pulse", e.sgl, lsu_single_ecc_error_incr);
      check_flag("idle", ~busy, lsu_idle);
    end
  end

  // ************************************************************************
  // Tests
  // ************************************************************************

  initial begin : stimulus
    lsu_addr_t   a;
    lsu_addr_t   b;
    lsu_size_e   sz;
    int unsigned bit1;
    int unsigned bit2;
    dccm_fdata_t mask;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_store      = 1'b0;
    req_unsigned   = 1'b0;
    req_size       = SIZE_BYTE;
    req_rs1        = '0;
    req_offset     = '0;
    req_store_data = '0;
    foreach (shadow[i]) shadow[i] = 8'h00;  // Matches the zeroed array
    foreach (sgl_word[i]) begin
      sgl_word[i] = 1'b0;
      dbl_word[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Back-to-back pairs hit dc3 and last-write forwarding
    for (int i = 0; i < 16; i++) begin
      a = rand_word_addr();
      b = rand_word_addr();
      issue(1'b1, 1'b0, SIZE_WORD, a, $random(seed));
      issue(1'b1, 1'b0, SIZE_WORD, b, $random(seed));
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);
      issue(1'b0, 1'b0, SIZE_WORD, b, '0);
    end
    end_test("word store/load");

    for (int i = 0; i < 10; i++) begin
      a = rand_word_addr();
      issue(1'b1, 1'b0, SIZE_BYTE, a + rnd(4), $random(seed));
      issue(1'b1, 1'b0, SIZE_HALF, a + 2 * rnd(2), $random(seed));
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);
      issue(1'b0, rnd(2) == 1, SIZE_HALF, a + 2 * rnd(2), '0);
      issue(1'b0, rnd(2) == 1, SIZE_BYTE, a + rnd(4), '0);
    end
    end_test("byte/half store/load");

    // Follow-up word load shows a faulting store wrote nothing
    for (int i = 0; i < 8; i++) begin
      a  = rand_word_addr();
      sz = (i % 4 < 2) ? SIZE_HALF : SIZE_WORD;
      b  = a + ((sz == SIZE_HALF) ? 1 + 2 * rnd(2) : 1 + rnd(3));
      issue(i % 2 == 1, 1'b0, sz, b, $random(seed));
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);
    end
    end_test("misaligned");

    for (int i = 0; i < 8; i++) begin
      if (i % 2 == 0) begin
        a = DCCM_BASE - 4 * (1 + rnd(64));  // Below the window
      end else begin
        a = DCCM_BASE + DCCM_SIZE + 4 * rnd(64);
      end
      issue(i >= 4, 1'b0, SIZE_WORD, a, $random(seed));
    end
    end_test("access fault");

    for (int i = 0; i < 4; i++) begin
      a    = rand_word_addr();
      mask = dccm_fdata_t'(1) << rnd(FDATA_WIDTH);  // Data, check or parity bit
      i_dccm_model.flip_bits(word_of(a), mask);
      sgl_word[word_of(a)] = 1'b1;
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);
      issue(1'b0, 1'b0, SIZE_BYTE, a + rnd(4), '0);
      drain();
      i_dccm_model.flip_bits(word_of(a), mask);
      sgl_word[word_of(a)] = 1'b0;
    end
    end_test("single ecc error");

    for (int i = 0; i < 3; i++) begin
      a    = rand_word_addr();
      bit1 = rnd(FDATA_WIDTH);
      bit2 = (bit1 + 1 + rnd(FDATA_WIDTH - 1)) % FDATA_WIDTH;  // Never equal to bit1
      mask = (dccm_fdata_t'(1) << bit1) | (dccm_fdata_t'(1) << bit2);
      i_dccm_model.flip_bits(word_of(a), mask);
      dbl_word[word_of(a)] = 1'b1;
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);
      issue(1'b1, 1'b0, SIZE_WORD, a, $random(seed));
      issue(1'b0, 1'b0, SIZE_HALF, a + 2 * rnd(2), '0);
      drain();
      i_dccm_model.flip_bits(word_of(a), mask);
      dbl_word[word_of(a)] = 1'b0;
      issue(1'b0, 1'b0, SIZE_WORD, a, '0);  // Old data since the store was dropped
      drain();
    end
    end_test("double ecc error");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/lsu_cfg_pkg.sv
source/lsu_types_pkg.sv
source/lsu_pipe_if.sv
source/lsu_ecc.sv
source/lsu_lsc_ctl.sv
source/lsu_dccm_ctl.sv
source/lsu_top.sv
dv/dccm_model.sv
dv/lsu_tb.sv

/* Makefile */
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP        := lsu_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
